//--- arb_pkg.sv
package arb_pkg;

    // switch geometry
    localparam int NUM_PORTS = 16;
    localparam int PRIO_W    = 3;   // higher value is more urgent
    localparam int WORD_W    = 32;

    // one bit per input port
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // port number, wide enough for NUM_PORTS
    typedef logic [3:0] port_idx_t;

    typedef logic [PRIO_W-1:0] prio_t;

    // weight w lets a port send w+1 packets per round
    typedef logic [2:0] weight_t;

    // packets left in the current round, up to weight+1
    typedef logic [3:0] credit_t;

    typedef logic [WORD_W-1:0] word_t;

    // per-port vectors, element i belongs to port i
    typedef prio_t   [NUM_PORTS-1:0] prio_vec_t;
    typedef weight_t [NUM_PORTS-1:0] weight_vec_t;
    typedef word_t   [NUM_PORTS-1:0] word_vec_t;

    // grant machine
    typedef enum logic {
        ARB_IDLE,
        ARB_XFER
    } arb_state_t;

    // completed packets, wraps
    typedef logic [15:0] pkt_count_t;

endpackage

//--- arb_switch.f
arb_pkg.sv
wrr_credit.sv
arbiter_core.sv
egress_mux.sv
arb_switch_top.sv
arb_switch_assertions.sv
tb_arb_switch.sv

//--- arb_switch_assertions.sv
`timescale 1ns/100ps

module arb_switch_assertions (
    input logic                 clk,
    input logic                 rst,
    input arb_pkg::port_mask_t  pop,
    input arb_pkg::port_mask_t  in_eop,
    input logic                 out_valid
);

    // at most one source popped at a time
    pop_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(pop))
        else $error("pop has more than one bit set");

    // egress register is one cycle behind pop
    valid_follows_pop: assert property (@(posedge clk) disable iff (rst)
        (pop != '0) |=> out_valid)
        else $error("out_valid missing one cycle after pop");

    no_valid_without_pop: assert property (@(posedge clk) disable iff (rst)
        (pop == '0) |=> !out_valid)
        else $error("out_valid without a pop the cycle before");

    // grant held until the eop word goes out
    pop_held_to_eop: assert property (@(posedge clk) disable iff (rst)
        ((pop != '0) && ((pop & in_eop) == '0)) |=> (pop != '0))
        else $error("pop dropped before the eop word");

    pop_gap_after_eop: assert property (@(posedge clk) disable iff (rst)
        ((pop & in_eop) != '0) |=> (pop == '0))
        else $error("pop still high the cycle after eop");

endmodule

bind arb_switch_top arb_switch_assertions u_arb_switch_assertions (
    .clk       (clk),
    .rst       (rst),
    .pop       (pop),
    .in_eop    (in_eop),
    .out_valid (out_valid)
);

//--- arb_switch_top.sv
`timescale 1ns/100ps

module arb_switch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wrr_mode,
    input  arb_pkg::port_mask_t   ready,
    input  arb_pkg::word_vec_t    in_data,
    input  arb_pkg::port_mask_t   in_eop,
    input  arb_pkg::prio_vec_t    prio,
    input  arb_pkg::weight_vec_t  weight,
    output arb_pkg::port_mask_t   pop,
    output logic                  out_valid,
    output arb_pkg::word_t        out_data,
    output logic                  out_eop,
    output arb_pkg::port_idx_t    out_port,
    output arb_pkg::pkt_count_t   pkt_count
);

    import arb_pkg::*;

    // core <-> credit block
    logic       grant_valid;
    port_idx_t  grant_port;
    port_mask_t eligible;
    logic       credit_any;

    // core -> egress
    port_idx_t  sel;

    wrr_credit u_wrr_credit (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .weight      (weight),
        .grant_valid (grant_valid),
        .grant_port  (grant_port),
        .eligible    (eligible),
        .credit_any  (credit_any)
    );

    arbiter_core u_arbiter_core (
        .clk         (clk),
        .rst         (rst),
        .wrr_mode    (wrr_mode),
        .ready       (ready),
        .in_eop      (in_eop),
        .prio        (prio),
        .eligible    (eligible),
        .credit_any  (credit_any),
        .pop         (pop),
        .sel         (sel),
        .busy        (),
        .grant_valid (grant_valid),
        .grant_port  (grant_port)
    );

    egress_mux u_egress_mux (
        .clk       (clk),
        .rst       (rst),
        .pop       (pop),
        .sel       (sel),
        .in_data   (in_data),
        .in_eop    (in_eop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_eop   (out_eop),
        .out_port  (out_port),
        .pkt_count (pkt_count)
    );

endmodule

//--- arbiter_core.sv
`timescale 1ns/100ps

module arbiter_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wrr_mode,      // 0 = strict priority, 1 = wrr
    input  arb_pkg::port_mask_t  ready,
    input  arb_pkg::port_mask_t  in_eop,
    input  arb_pkg::prio_vec_t   prio,
    input  arb_pkg::port_mask_t  eligible,
    input  logic                 credit_any,
    output arb_pkg::port_mask_t  pop,
    output arb_pkg::port_idx_t   sel,
    output logic                 busy,
    output logic                 grant_valid,
    output arb_pkg::port_idx_t   grant_port
);

    import arb_pkg::*;

    arb_state_t state;
    port_idx_t  rr_ptr;     // wrr search starts here
    port_mask_t wrr_cand;
    port_idx_t  sp_win;
    port_idx_t  wrr_win;
    port_idx_t  winner;

    // highest priority among req, lowest index on a tie
    function automatic port_idx_t sp_pick(input port_mask_t req, input prio_vec_t pv);
        port_idx_t win;
        prio_t     best;
        logic      found;
        win   = '0;
        best  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            // strict compare keeps the earlier index on equal priority
            if (req[i] && (!found || pv[i] > best)) begin
                win   = port_idx_t'(i);
                best  = pv[i];
                found = 1'b1;
            end
        end
        return win;
    endfunction

    // first requester at or after ptr, wrapping around
    function automatic port_idx_t wrr_pick(input port_mask_t req, input port_idx_t ptr);
        port_idx_t win;
        port_idx_t idx;
        win = ptr;
        // walk backwards so the nearest candidate is written last
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = port_idx_t'(int'(ptr) + k);
            if (req[idx]) begin
                win = idx;
            end
        end
        return win;
    endfunction

    // once every ready port is out of credit, fall back to plain ready
    assign wrr_cand = credit_any ? eligible : ready;

    assign sp_win  = sp_pick(ready, prio);
    assign wrr_win = wrr_pick(wrr_cand, rr_ptr);
    assign winner  = wrr_mode ? wrr_win : sp_win;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ARB_IDLE;
            pop         <= '0;
            sel         <= '0;
            grant_valid <= 1'b0;
            rr_ptr      <= '0;
        end else begin
            grant_valid <= 1'b0;    // single-cycle strobe
            case (state)
                ARB_IDLE: begin
                    if (|ready) begin
                        sel         <= winner;
                        pop         <= port_mask_t'(1) << winner;
                        grant_valid <= 1'b1;
                        state       <= ARB_XFER;
                        if (wrr_mode) begin
                            rr_ptr <= wrr_win + 1'b1;   // wraps at 16
                        end
                    end
                end
                ARB_XFER: begin
                    // hold the grant until the eop word is taken
                    if (in_eop[sel]) begin
                        pop   <= '0;
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    pop   <= '0;
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    assign busy       = (state == ARB_XFER);
    assign grant_port = sel;    // sel is loaded on the same edge as the strobe

endmodule

//--- egress_mux.sv
`timescale 1ns/100ps

module egress_mux (
    input  logic                 clk,
    input  logic                 rst,
    input  arb_pkg::port_mask_t  pop,
    input  arb_pkg::port_idx_t   sel,
    input  arb_pkg::word_vec_t   in_data,
    input  arb_pkg::port_mask_t  in_eop,
    output logic                 out_valid,
    output arb_pkg::word_t       out_data,
    output logic                 out_eop,
    output arb_pkg::port_idx_t   out_port,
    output arb_pkg::pkt_count_t  pkt_count
);

    logic any_pop;
    logic last_word;

    assign any_pop   = |pop;
    assign last_word = pop[sel] & in_eop[sel];    // eop word consumed this edge

    // egress control, one cycle behind pop
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_eop   <= 1'b0;
            pkt_count <= '0;
        end else begin
            out_valid <= any_pop;
            out_eop   <= last_word;
            if (last_word) begin
                pkt_count <= pkt_count + 1'b1;    // wraps
            end
        end
    end

    // payload stage
    always_ff @(posedge clk) begin
        if (any_pop) begin
            out_data <= in_data[sel];
            out_port <= sel;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the arb_switch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_arb_switch \
    -f arb_switch.f \
    -o Vtb_arb_switch > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_arb_switch > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$SIM_LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation ok"
exit 0

//--- tb_arb_switch.sv
`timescale 1ns/100ps

module tb_arb_switch;

    import arb_pkg::*;

    localparam int TOTAL_WORDS     = 170;   // upper bound over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 3 + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        wrr_mode;
    port_mask_t  ready   = '0;
    word_vec_t   in_data = '0;
    port_mask_t  in_eop  = '0;
    prio_vec_t   prio;
    weight_vec_t weight;
    port_mask_t  pop;
    logic        out_valid;
    word_t       out_data;
    logic        out_eop;
    port_idx_t   out_port;
    pkt_count_t  pkt_count;

    // source models, one flat word queue per port
    word_t     src_words [NUM_PORTS][$];
    logic      src_eop   [NUM_PORTS][$];
    // scoreboard
    word_t     exp_word [$];
    port_idx_t exp_port [$];
    logic      exp_eop  [$];
    port_idx_t obs_ports [$];   // port of each finished packet

    logic ref_idle;
    int   ref_ptr;
    int   ref_port;
    int   ref_credit [NUM_PORTS];
    int   errors;
    int   checks;
    int   tests;
    int   sent;

    arb_switch_top u_arb_switch_top (.*);

    always #4 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input port_idx_t got, input port_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_eop(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input pkt_count_t got, input pkt_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    // monitor, reference model and source models in one block
    always @(posedge clk) begin : model
        int         win;
        int         best;
        int         idx;
        logic       any_cr;
        port_mask_t cand;
        if (rst) begin
            ref_idle = 1'b1;
            ref_ptr  = 0;
            for (int p = 0; p < NUM_PORTS; p++) ref_credit[p] = int'(weight[p]) + 1;
            exp_word.delete();
            exp_port.delete();
            exp_eop.delete();
        end else begin
            if (out_valid) begin
                if (exp_word.size() == 0) begin
                    errors++;
                    $display("t=%0t egress showed a word while none was expected", $time);
                end else begin
                    check_word("out_data", out_data, exp_word.pop_front());
                    check_port("out_port", out_port, exp_port.pop_front());
                    check_eop("out_eop", out_eop, exp_eop.pop_front());
                    if (out_eop) obs_ports.push_back(out_port);
                end
            end
            if (ref_idle && ready != '0) begin
                any_cr = 1'b0;
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (ready[p] && ref_credit[p] > 0) any_cr = 1'b1;
                end
                win = -1;
                if (wrr_mode) begin
                    cand = ready;
                    for (int p = 0; p < NUM_PORTS; p++) begin
                        if (any_cr && ref_credit[p] == 0) cand[p] = 1'b0;
                    end
                    for (int k = 0; k < NUM_PORTS; k++) begin
                        idx = (ref_ptr + k) % NUM_PORTS;
                        if (win < 0 && cand[idx]) win = idx;
                    end
                    ref_ptr = (win + 1) % NUM_PORTS;
                end else begin
                    best = -1;
                    for (int p = 0; p < NUM_PORTS; p++) begin
                        if (ready[p] && int'(prio[p]) > best) begin
                            win  = p;
                            best = int'(prio[p]);
                        end
                    end
                end
                if (any_cr) begin
                    if (ref_credit[win] > 0) ref_credit[win]--;
                end else begin
                    for (int p = 0; p < NUM_PORTS; p++) begin
                        ref_credit[p] = int'(weight[p]) + ((p == win) ? 0 : 1);
                    end
                end
                idx = 0;
                do begin
                    exp_word.push_back(src_words[win][idx]);
                    exp_port.push_back(port_idx_t'(win));
                    exp_eop.push_back(src_eop[win][idx]);
                    idx++;
                end while (!src_eop[win][idx-1]);
                ref_idle = 1'b0;
                ref_port = win;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (pop[p] && src_words[p].size() > 0) begin
                    if (src_eop[p][0] && p == ref_port) ref_idle = 1'b1;
                    void'(src_words[p].pop_front());
                    void'(src_eop[p].pop_front());
                end
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            ready[p]   <= (src_words[p].size() > 0);
            in_data[p] <= (src_words[p].size() > 0) ? src_words[p][0] : '0;
            in_eop[p]  <= (src_eop[p].size() > 0) ? src_eop[p][0] : 1'b0;
        end
    end

    task automatic add_packet(input int port, input int len);
        for (int i = 0; i < len; i++) begin
            src_words[port].push_back($urandom());
            src_eop[port].push_back(i == len - 1);
        end
        sent++;
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        sent = 0;
    endtask

    task automatic wait_drain();
        int n;
        int busy_ports;
        n = 0;
        do begin
            @(negedge clk);
            busy_ports = 0;
            for (int p = 0; p < NUM_PORTS; p++) busy_ports += src_words[p].size();
            n++;
        end while ((busy_ports > 0 || exp_word.size() > 0 || pop != '0 || out_valid) && n < 600);
        if (n >= 600) begin
            errors++;
            $display("t=%0t traffic did not drain", $time);
        end
    endtask

    task automatic check_order(input port_idx_t order [$]);
        if (obs_ports.size() != order.size()) begin
            errors++;
            $display("t=%0t saw %0d packets, expected %0d", $time, obs_ports.size(), order.size());
        end else begin
            foreach (order[i]) check_port("packet port", obs_ports[i], order[i]);
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (errors == err_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic single_packet_test();
        int e0;
        int n;
        e0 = errors;
        @(negedge clk);
        add_packet(3, 1 + ($urandom() % 6));
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!out_valid && n < 20);
        // ready shows up after the first edge, out_valid two edges later
        if (n != 3) begin
            errors++;
            $display("t=%0t first word came %0d cycles after ready, expected 2", $time, n - 1);
        end
        wait_drain();
        check_count("pkt_count", pkt_count, pkt_count_t'(sent));
        report("single_packet", e0);
    endtask

    task automatic sp_order_test();
        int e0;
        e0 = errors;
        @(posedge clk);
        prio <= '0;
        prio[0] <= 3'd2;
        prio[1] <= 3'd5;
        prio[2] <= 3'd5;
        prio[3] <= 3'd7;
        prio[4] <= 3'd2;
        @(negedge clk);
        obs_ports.delete();
        for (int p = 0; p < 6; p++) add_packet(p, 1 + ($urandom() % 6));
        wait_drain();
        check_order('{4'd3, 4'd1, 4'd2, 4'd0, 4'd4, 4'd5});
        check_count("pkt_count", pkt_count, pkt_count_t'(sent));
        report("sp_order", e0);
    endtask

    task automatic atomicity_test();
        int e0;
        e0 = errors;
        @(posedge clk);
        prio[1] <= 3'd1;
        prio[7] <= 3'd7;
        @(negedge clk);
        obs_ports.delete();
        add_packet(1, 5);
        while (!out_valid) @(negedge clk);
        add_packet(7, 2);   // urgent newcomer mid-packet
        wait_drain();
        check_order('{4'd1, 4'd7});
        check_count("pkt_count", pkt_count, pkt_count_t'(sent));
        report("atomicity", e0);
    endtask

    task automatic wrr_share_test();
        int         e0;
        port_idx_t  order [$];
        e0 = errors;
        @(posedge clk);
        weight    <= '0;
        weight[5] <= 3'd1;
        weight[9] <= 3'd2;
        wrr_mode  <= 1'b1;
        do_reset();     // credits reload from the new weights
        @(negedge clk);
        obs_ports.delete();
        for (int i = 0; i < 3; i++) add_packet(2, 1 + ($urandom() % 6));
        for (int i = 0; i < 6; i++) add_packet(5, 1 + ($urandom() % 6));
        for (int i = 0; i < 9; i++) add_packet(9, 1 + ($urandom() % 6));
        for (int r = 0; r < 3; r++) begin
            order.push_back(4'd2);
            order.push_back(4'd5);
            order.push_back(4'd9);
            order.push_back(4'd5);
            order.push_back(4'd9);
            order.push_back(4'd9);
        end
        wait_drain();
        check_order(order);
        check_count("pkt_count", pkt_count, pkt_count_t'(sent));
        @(posedge clk);
        wrr_mode <= 1'b0;
        report("wrr_shares", e0);
    endtask

    task automatic count_test();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_count("pkt_count", pkt_count, pkt_count_t'(sent));
        do_reset();
        @(negedge clk);
        check_count("pkt_count after reset", pkt_count, '0);
        add_packet(6, 1 + ($urandom() % 6));
        wait_drain();
        check_count("pkt_count", pkt_count, pkt_count_t'(sent));
        report("packet_count", e0);
    endtask

    initial begin
        void'($urandom(32'h9048));
        errors   = 0;
        checks   = 0;
        tests    = 0;
        sent     = 0;
        ref_port = 0;
        rst      <= 1'b1;
        wrr_mode <= 1'b0;
        prio     <= '0;
        weight   <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        single_packet_test();
        sp_order_test();
        atomicity_test();
        wrr_share_test();
        count_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- wrr_credit.sv
`timescale 1ns/100ps

module wrr_credit (
    input  logic                  clk,
    input  logic                  rst,
    input  arb_pkg::port_mask_t   ready,
    input  arb_pkg::weight_vec_t  weight,
    input  logic                  grant_valid,
    input  arb_pkg::port_idx_t    grant_port,
    output arb_pkg::port_mask_t   eligible,
    output logic                  credit_any
);

    import arb_pkg::*;

    credit_t    credit [NUM_PORTS];   // packets left this round
    port_mask_t has_credit;

    // credit for a fresh round
    function automatic credit_t full_credit(input weight_t w);
        return credit_t'(w) + credit_t'(1);
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            has_credit[i] = (credit[i] != '0);
        end
    end

    assign eligible   = ready & has_credit;
    assign credit_any = |eligible;    // low means the round is used up

    // grant_valid arrives one cycle after the core picked grant_port,
    // so the update lands at the edge that follows it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                credit[i] <= full_credit(weight[i]);
            end
        end else if (grant_valid) begin
            if (credit_any) begin
                // winner still inside its share
                if (credit[grant_port] != '0) begin
                    credit[grant_port] <= credit[grant_port] - 1'b1;
                end
            end else begin
                // new round, winner already spends one packet of it
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (port_idx_t'(i) == grant_port) begin
                        credit[i] <= credit_t'(weight[i]);
                    end else begin
                        credit[i] <= full_credit(weight[i]);
                    end
                end
            end
        end
    end

endmodule
